/* logic/ntm_output_pkg.sv */
// Shared types and default widths for the output vector block, imported by its modules
`default_nettype none

package ntm_output_pkg;

  ////////////////////
  // Default widths
  ////////////////////

  // Element width of K, r, nu and y
  localparam int DEF_DATA_SIZE = 16;

  // Width of size inputs and index counters
  localparam int DEF_DIM_W = 4;

  ////////////////////
  // Enums
  ////////////////////

  // Controller phases
  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_PRODUCT = 2'd1,
    ST_ADD     = 2'd2,
    ST_OUTPUT  = 2'd3
  } ntm_state_e;

  // Accumulator operations
  typedef enum logic [1:0] {
    ACC_HOLD  = 2'd0,
    ACC_CLEAR = 2'd1,
    ACC_MAC   = 2'd2
  } ntm_acc_op_e;

endpackage

`default_nettype wire

/* logic/ntm_output_ctrl.sv */
// Phase FSM of the output vector block that owns all stream handshakes and data strobes
`timescale 1ns/100ps
`default_nettype none

module ntm_output_ctrl
  import ntm_output_pkg::*;
(
  input  wire         CLK,
  input  wire         RST,
  input  wire         start,
  input  wire         kr_valid,
  input  wire         nu_valid,
  input  wire         y_ready,
  input  wire         pair_last,
  input  wire         item_last,
  output logic        kr_ready,
  output logic        nu_ready,
  output logic        y_valid,
  output logic        busy,
  output logic        done,
  output ntm_acc_op_e acc_op,
  output logic        sum_load,
  output logic        pair_step,
  output logic        item_step,
  output logic        size_load
);

  ntm_state_e state;
  ntm_state_e state_next;

  // Completed transfers on each stream
  logic kr_xfer;
  logic nu_xfer;
  logic y_xfer;

  ////////////////////
  // Handshakes
  ////////////////////

  // Readies and valids come straight from the phase
  assign kr_ready = (state == ST_PRODUCT);
  assign nu_ready = (state == ST_ADD);
  assign y_valid  = (state == ST_OUTPUT);
  assign busy     = (state != ST_IDLE);

  assign kr_xfer = kr_valid & kr_ready;
  assign nu_xfer = nu_valid & nu_ready;
  assign y_xfer  = y_valid & y_ready;

  ////////////////////
  // Next state and strobes
  ////////////////////

  always_comb begin
    state_next = state;
    acc_op     = ACC_HOLD;
    sum_load   = 1'b0;
    pair_step  = 1'b0;
    item_step  = 1'b0;
    size_load  = 1'b0;
    case (state)
      ST_IDLE: begin
        // Start only counts here, later pulses are ignored
        if (start) begin
          size_load  = 1'b1;
          acc_op     = ACC_CLEAR;
          state_next = ST_PRODUCT;
        end
      end
      ST_PRODUCT: begin
        if (kr_xfer) begin
          pair_step = 1'b1;
          acc_op    = ACC_MAC;
          if (pair_last) begin
            state_next = ST_ADD;
          end
        end
      end
      ST_ADD: begin
        // Bias arrives, sum goes to the output register
        if (nu_xfer) begin
          sum_load   = 1'b1;
          state_next = ST_OUTPUT;
        end
      end
      ST_OUTPUT: begin
        if (y_xfer) begin
          item_step = 1'b1;
          if (item_last) begin
            state_next = ST_IDLE;
          end else begin
            acc_op     = ACC_CLEAR;
            state_next = ST_PRODUCT;
          end
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  ////////////////////
  // State and done
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= ST_IDLE;
      done  <= 1'b0;
    end else begin
      state <= state_next;
      // One cycle pulse after the final y leaves
      done  <= y_xfer & item_last;
    end
  end

endmodule

`default_nettype wire

/* logic/ntm_index_counter.sv */
// Pair and output index counters with last flags, driven by the controller strobes
`timescale 1ns/100ps
`default_nettype none

module ntm_index_counter #(
  parameter int DIM_W = 4
) (
  input  wire             CLK,
  input  wire             RST,
  input  wire             size_load,
  input  wire             pair_step,
  input  wire             item_step,
  input  wire [DIM_W-1:0] size_y,
  input  wire [DIM_W-1:0] size_r,
  input  wire [DIM_W-1:0] size_w,
  output logic            pair_last,
  output logic            item_last
);

  // Sizes captured at start
  logic [DIM_W-1:0] size_y_q;
  logic [DIM_W-1:0] size_r_q;
  logic [DIM_W-1:0] size_w_q;

  // k runs inside i, y counts outputs
  logic [DIM_W-1:0] k_idx;
  logic [DIM_W-1:0] i_idx;
  logic [DIM_W-1:0] y_idx;

  logic k_last;
  logic i_last;

  assign k_last    = (k_idx == size_w_q - 1'b1);
  assign i_last    = (i_idx == size_r_q - 1'b1);
  assign pair_last = k_last & i_last;
  assign item_last = (y_idx == size_y_q - 1'b1);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      size_y_q <= '0;
      size_r_q <= '0;
      size_w_q <= '0;
      k_idx    <= '0;
      i_idx    <= '0;
      y_idx    <= '0;
    end else if (size_load) begin
      size_y_q <= size_y;
      size_r_q <= size_r;
      size_w_q <= size_w;
      k_idx    <= '0;
      i_idx    <= '0;
      y_idx    <= '0;
    end else if (item_step) begin
      // New output element, pair walk restarts
      k_idx <= '0;
      i_idx <= '0;
      y_idx <= item_last ? '0 : y_idx + 1'b1;
    end else if (pair_step) begin
      if (k_last) begin
        k_idx <= '0;
        i_idx <= i_last ? '0 : i_idx + 1'b1;
      end else begin
        k_idx <= k_idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/ntm_dot_accumulator.sv */
// Streaming multiply-accumulate for one K·r dot product, wrapping at DATA_SIZE bits
`timescale 1ns/100ps
`default_nettype none

module ntm_dot_accumulator
  import ntm_output_pkg::*;
#(
  parameter int DATA_SIZE = 16
) (
  input  wire                 CLK,
  input  wire                 RST,
  input  ntm_acc_op_e         acc_op,
  input  wire [DATA_SIZE-1:0] k_data,
  input  wire [DATA_SIZE-1:0] r_data,
  output logic [DATA_SIZE-1:0] acc_data
);

  ////////////////////
  // Product
  ////////////////////

  // Low half of K·r only, upper bits wrap away
  logic [DATA_SIZE-1:0] prod_low;
  logic [DATA_SIZE-1:0] mac_sum;

  assign prod_low = k_data * r_data;
  assign mac_sum  = acc_data + prod_low;

  ////////////////////
  // Accumulator register
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      acc_data <= '0;
    end else begin
      case (acc_op)
        ACC_CLEAR: begin
          acc_data <= '0;
        end
        ACC_MAC: begin
          // One pair per transfer
          acc_data <= mac_sum;
        end
        default: begin
          acc_data <= acc_data;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/ntm_vector_adder.sv */
// Output register that adds nu to the finished dot product and holds y for the host
`timescale 1ns/100ps
`default_nettype none

module ntm_vector_adder #(
  parameter int DATA_SIZE = 16
) (
  input  wire                  CLK,
  input  wire                  RST,
  input  wire                  sum_load,
  input  wire  [DATA_SIZE-1:0] acc_data,
  input  wire  [DATA_SIZE-1:0] nu_data,
  output logic [DATA_SIZE-1:0] y_data
);

  // Wrapped bias add
  logic [DATA_SIZE-1:0] sum;

  assign sum = acc_data + nu_data;

  // Held stable through output back-pressure
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      y_data <= '0;
    end else if (sum_load) begin
      y_data <= sum;
    end
  end

endmodule

`default_nettype wire

/* logic/ntm_output_vector.sv */
// Top level of the output vector block y = K·r + nu with kr, nu and y valid/ready streams
`timescale 1ns/100ps
`default_nettype none

module ntm_output_vector
  import ntm_output_pkg::*;
#(
  parameter int DATA_SIZE = DEF_DATA_SIZE,
  parameter int DIM_W     = DEF_DIM_W
) (
  input  wire                  CLK,
  input  wire                  RST,

  // Control
  input  wire                  start,
  output logic                 busy,
  output logic                 done,
  input  wire  [DIM_W-1:0]     size_y,
  input  wire  [DIM_W-1:0]     size_r,
  input  wire  [DIM_W-1:0]     size_w,

  // kr stream
  input  wire  [DATA_SIZE-1:0] k_data,
  input  wire  [DATA_SIZE-1:0] r_data,
  input  wire                  kr_valid,
  output logic                 kr_ready,

  // nu stream
  input  wire  [DATA_SIZE-1:0] nu_data,
  input  wire                  nu_valid,
  output logic                 nu_ready,

  // y stream
  output logic [DATA_SIZE-1:0] y_data,
  output logic                 y_valid,
  input  wire                  y_ready
);

  ////////////////////
  // Internal nets
  ////////////////////

  ntm_acc_op_e          acc_op;
  logic                 sum_load;
  logic                 pair_step;
  logic                 item_step;
  logic                 size_load;
  logic                 pair_last;
  logic                 item_last;
  logic [DATA_SIZE-1:0] acc_data;

  ////////////////////
  // Control
  ////////////////////

  ntm_output_ctrl ctrl_i (
    .CLK       (CLK),
    .RST       (RST),
    .start     (start),
    .kr_valid  (kr_valid),
    .nu_valid  (nu_valid),
    .y_ready   (y_ready),
    .pair_last (pair_last),
    .item_last (item_last),
    .kr_ready  (kr_ready),
    .nu_ready  (nu_ready),
    .y_valid   (y_valid),
    .busy      (busy),
    .done      (done),
    .acc_op    (acc_op),
    .sum_load  (sum_load),
    .pair_step (pair_step),
    .item_step (item_step),
    .size_load (size_load)
  );

  // Index tracking for i, k and y
  ntm_index_counter #(
    .DIM_W (DIM_W)
  ) counter_i (
    .CLK       (CLK),
    .RST       (RST),
    .size_load (size_load),
    .pair_step (pair_step),
    .item_step (item_step),
    .size_y    (size_y),
    .size_r    (size_r),
    .size_w    (size_w),
    .pair_last (pair_last),
    .item_last (item_last)
  );

  ////////////////////
  // Datapath
  ////////////////////

  ntm_dot_accumulator #(
    .DATA_SIZE (DATA_SIZE)
  ) accumulator_i (
    .CLK      (CLK),
    .RST      (RST),
    .acc_op   (acc_op),
    .k_data   (k_data),
    .r_data   (r_data),
    .acc_data (acc_data)
  );

  ntm_vector_adder #(
    .DATA_SIZE (DATA_SIZE)
  ) adder_i (
    .CLK      (CLK),
    .RST      (RST),
    .sum_load (sum_load),
    .acc_data (acc_data),
    .nu_data  (nu_data),
    .y_data   (y_data)
  );

endmodule

`default_nettype wire

/* dv/ntm_output_vector_chk.sv */
// Handshake and phase assertions for the output FSM, bound into the controller by the testbench
`timescale 1ns/100ps
`default_nettype none

module ntm_output_vector_chk
  import ntm_output_pkg::*;
(
  input wire             CLK,
  input wire             RST,
  input wire ntm_state_e state,
  input wire             kr_valid,
  input wire             kr_ready,
  input wire             pair_last,
  input wire             nu_ready,
  input wire             y_valid,
  input wire             y_ready,
  input wire             busy,
  input wire             done
);

  // Everything quiet while reset is held
  reset_quiet_a: assert property (@(posedge CLK)
    RST |-> (state == ST_IDLE) && !kr_ready && !nu_ready && !y_valid && !busy && !done)
    else $error("Handshake outputs active during reset");

  // Product and add phases never overlap, add opens only after the last pair
  ready_excl_a: assert property (@(posedge CLK) disable iff (RST)
    !(kr_ready && nu_ready) &&
    (!$rose(nu_ready) || $past(kr_valid && kr_ready && pair_last)))
    else $error("kr_ready and nu_ready overlap or add phase opened early");

  // Stalled output keeps its valid
  y_hold_a: assert property (@(posedge CLK) disable iff (RST) (y_valid && !y_ready) |=> y_valid)
    else $error("y_valid dropped before y_ready");

  done_pulse_a: assert property (@(posedge CLK) disable iff (RST) done |=> !done)
    else $error("done longer than one cycle");

endmodule

`default_nettype wire

/* dv/ntm_output_vector_tb.sv */
// Testbench for the output vector block with random streams, stalls and a reference model
`timescale 1ns/100ps
`default_nettype none

module ntm_output_vector_tb;

  localparam int DATA_SIZE = 16;
  localparam int DIM_W     = 4;
  localparam int RUNS      = 6;

  logic                 CLK;
  logic                 RST;
  logic                 start;
  logic [DIM_W-1:0]     size_y;
  logic [DIM_W-1:0]     size_r;
  logic [DIM_W-1:0]     size_w;
  logic [DATA_SIZE-1:0] k_data;
  logic [DATA_SIZE-1:0] r_data;
  logic [DATA_SIZE-1:0] nu_data;
  logic                 kr_valid;
  logic                 nu_valid;
  logic                 y_ready;
  logic                 busy;
  logic                 done;
  logic                 kr_ready;
  logic                 nu_ready;
  logic                 y_valid;
  logic [DATA_SIZE-1:0] y_data;

  integer seed = 64143;
  integer ready_seed;
  int     cycle_cnt = 0;
  int     cycle_limit = 0;
  int     done_cnt = 0;
  int     run_sy [RUNS];
  int     run_sr [RUNS];
  int     run_sw [RUNS];

  // Stimulus store, row y at offset y*16
  logic [DATA_SIZE-1:0] k_mem [64];
  logic [DATA_SIZE-1:0] r_mem [64];
  logic [DATA_SIZE-1:0] nu_mem [4];
  logic [DATA_SIZE-1:0] exp_q [$];
  logic                 stalled = 1'b0;
  logic [DATA_SIZE-1:0] held_y;

  initial CLK = 1'b0;
  always #5 CLK = ~CLK;

  ntm_output_vector #(.DATA_SIZE(DATA_SIZE), .DIM_W(DIM_W)) dut_i (
    .CLK(CLK), .RST(RST), .start(start), .busy(busy), .done(done),
    .size_y(size_y), .size_r(size_r), .size_w(size_w),
    .k_data(k_data), .r_data(r_data), .kr_valid(kr_valid), .kr_ready(kr_ready),
    .nu_data(nu_data), .nu_valid(nu_valid), .nu_ready(nu_ready),
    .y_data(y_data), .y_valid(y_valid), .y_ready(y_ready)
  );

  bind ntm_output_ctrl ntm_output_vector_chk chk_i (
    .CLK(CLK), .RST(RST), .state(state), .kr_valid(kr_valid), .kr_ready(kr_ready),
    .pair_last(pair_last), .nu_ready(nu_ready),
    .y_valid(y_valid), .y_ready(y_ready), .busy(busy), .done(done)
  );

  ////////////////////
  // Reference model
  ////////////////////

  // Half the words sit near the top of the range to force wraparound
  function automatic logic [DATA_SIZE-1:0] rand_word();
    logic [DATA_SIZE-1:0] w;
    w = $random(seed);
    if (w[0]) w = w | 16'hFF00;
    return w;
  endfunction

  // y = sum of K*r plus nu, kept to 16 bits at every step
  function automatic logic [DATA_SIZE-1:0] ref_y(input int yi, input int pairs);
    logic [DATA_SIZE-1:0] acc;
    acc = '0;
    for (int p = 0; p < pairs; p++) begin
      acc = acc + k_mem[yi*16+p] * r_mem[yi*16+p];
    end
    return acc + nu_mem[yi];
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s got 0x%0h, expected 0x%0h", $time, what, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  ////////////////////
  // Stream drivers
  ////////////////////

  // poke raises start during the pair, while the DUT is busy
  task automatic send_pair(input logic [DATA_SIZE-1:0] k, input logic [DATA_SIZE-1:0] r,
                           input logic poke);
    while (({$random(seed)} % 4) == 0) @(negedge CLK);
    k_data   = k;
    r_data   = r;
    kr_valid = 1'b1;
    start    = poke;
    @(posedge CLK);
    while (!kr_ready) @(posedge CLK);
    @(negedge CLK);
    kr_valid = 1'b0;
    start    = 1'b0;
  endtask

  task automatic send_nu(input logic [DATA_SIZE-1:0] nu);
    while (({$random(seed)} % 4) == 0) @(negedge CLK);
    nu_data  = nu;
    nu_valid = 1'b1;
    @(posedge CLK);
    while (!nu_ready) @(posedge CLK);
    @(negedge CLK);
    nu_valid = 1'b0;
  endtask

  // One full vector, entered and left on a falling edge
  task automatic run_vector(input int sy, input int sr, input int sw);
    int pairs;
    pairs = sr * sw;
    for (int y = 0; y < sy; y++) begin
      for (int p = 0; p < pairs; p++) begin
        k_mem[y*16+p] = rand_word();
        r_mem[y*16+p] = rand_word();
      end
      nu_mem[y] = rand_word();
      exp_q.push_back(ref_y(y, pairs));
    end
    size_y = DIM_W'(sy);
    size_r = DIM_W'(sr);
    size_w = DIM_W'(sw);
    start  = 1'b1;
    @(negedge CLK);
    start  = 1'b0;
    for (int y = 0; y < sy; y++) begin
      for (int p = 0; p < pairs; p++) begin
        send_pair(k_mem[y*16+p], r_mem[y*16+p], (y == 0) && (p == 0));
      end
      send_nu(nu_mem[y]);
    end
    @(posedge CLK);
    while (!done) @(posedge CLK);
    @(negedge CLK);
    done_cnt_exp_check();
  endtask

  task automatic done_cnt_exp_check();
    check(busy, 0, "busy after done");
    check(exp_q.size(), 0, "outputs still pending");
  endtask

  ////////////////////
  // Back-pressure, comparison, timeout
  ////////////////////

  always @(negedge CLK) begin
    y_ready = ({$random(ready_seed)} % 4) != 0;
  end

  always @(posedge CLK) begin
    if (!RST) begin
      if (stalled && y_valid) check(y_data, held_y, "y_data while stalled");
      stalled <= y_valid && !y_ready;
      held_y  <= y_data;
      if (done) done_cnt <= done_cnt + 1;
      if (y_valid && y_ready) begin
        if (exp_q.size() == 0) begin
          $display("A y transfer arrived with no output pending");
          $display("TEST RESULT: FAIL");
          $fatal(1, "Extra output");
        end else begin
          check(y_data, exp_q.pop_front(), "y_data");
        end
      end
    end
  end

  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Timeout");
    end
  end

  initial begin
    int total;
    RST      = 1'b1;
    start    = 1'b0;
    size_y   = '0;
    size_r   = '0;
    size_w   = '0;
    k_data   = '0;
    r_data   = '0;
    nu_data  = '0;
    kr_valid = 1'b0;
    nu_valid = 1'b0;
    y_ready  = 1'b0;
    ready_seed = seed + 1;
    // First run is the all-ones case
    total = 0;
    for (int n = 0; n < RUNS; n++) begin
      run_sy[n] = (n == 0) ? 1 : 1 + ({$random(seed)} % 4);
      run_sr[n] = (n == 0) ? 1 : 1 + ({$random(seed)} % 4);
      run_sw[n] = (n == 0) ? 1 : 1 + ({$random(seed)} % 4);
      total += run_sy[n] * run_sr[n] * run_sw[n] + run_sy[n];
    end
    cycle_limit = 20 * total + 200;
    repeat (10) @(negedge CLK);
    RST = 1'b0;
    // Idle with no start
    repeat (5) begin
      @(posedge CLK);
      check({kr_ready, nu_ready, y_valid, busy, done}, 0, "idle outputs");
    end
    @(negedge CLK);
    for (int n = 0; n < RUNS; n++) begin
      run_vector(run_sy[n], run_sr[n], run_sw[n]);
      check(done_cnt, n + 1, "done pulse count");
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* ntm_output.f */
logic/ntm_output_pkg.sv
logic/ntm_output_ctrl.sv
logic/ntm_index_counter.sv
logic/ntm_dot_accumulator.sv
logic/ntm_vector_adder.sv
logic/ntm_output_vector.sv
dv/ntm_output_vector_chk.sv
dv/ntm_output_vector_tb.sv
